// File: rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // base opcodes of rv32i.
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // arithmetic funct3.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

// File: id_ctrl_pkg.sv
package id_ctrl_pkg;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // lui result is the immediate itself.
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // execute word, msb first:
    // alu_op[3:0], alu_src_imm, alu_src_pc, is_branch, is_jump, is_jalr.
    typedef logic [8:0] ex_ctrl_t;

    // memory word, msb first:
    // mem_read, mem_write, funct3[2:0] of the access.
    typedef logic [4:0] mem_ctrl_t;

    // write-back word, msb first:
    // reg_write, mem_to_reg.
    typedef logic [1:0] wb_ctrl_t;

    // all-zero words are a bubble.
    localparam ex_ctrl_t  EX_NOP  = '0;
    localparam mem_ctrl_t MEM_NOP = '0;
    localparam wb_ctrl_t  WB_NOP  = '0;

endpackage

// File: imm_gen.sv
module imm_gen (
    input  rv_isa_pkg::data_t inst,
    output rv_isa_pkg::data_t imm
);
    import rv_isa_pkg::*;

    opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            OP_LOAD, OP_IMM, OP_JALR: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OP_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: reg_file.sv
module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  rv_isa_pkg::reg_idx_t rd,
    input  rv_isa_pkg::data_t    wdata,
    input  logic                 we,
    output rv_isa_pkg::data_t    rdata1,
    output rv_isa_pkg::data_t    rdata2
);
    import rv_isa_pkg::*;

    // x0 has no storage.
    data_t regs [1:31];

    function automatic data_t read_port(input reg_idx_t idx);
        data_t val;
        if (idx == '0) begin
            val = '0;
        end else if (we && idx == rd) begin
            // write-back in the same cycle wins.
            val = wdata;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(rs1);
        rdata2 = read_port(rs2);
    end

    // a write-back to x0 must never leak through the bypass.
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1 == '0) |-> (rdata1 == '0)) and ((rs2 == '0) |-> (rdata2 == '0)));

endmodule

// File: hazard_unit.sv
module hazard_unit (
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  rv_isa_pkg::reg_idx_t id_ex_rd,
    input  logic                 id_ex_mem_read,
    output logic                 stall,
    output logic                 if_id_write,
    output logic                 pc_write
);

    logic rd_match;

    // x0 as a load target never creates a dependency.
    assign rd_match = (id_ex_rd != '0) && ((id_ex_rd == rs1) || (id_ex_rd == rs2));

    assign stall       = id_ex_mem_read && rd_match;
    assign if_id_write = !stall;
    assign pc_write    = !stall;

endmodule

// File: ctrl_decode.sv
module ctrl_decode (
    input  rv_isa_pkg::data_t      inst,
    output id_ctrl_pkg::ex_ctrl_t  ex_ctrl,
    output id_ctrl_pkg::mem_ctrl_t mem_ctrl,
    output id_ctrl_pkg::wb_ctrl_t  wb_ctrl,
    output logic                   branch,
    output logic                   jump,
    output logic                   jalr,
    output logic                   ujtype,
    output logic                   excp
);
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    alu_op;
    logic       src_imm;
    logic       src_pc;
    logic       mem_rd;
    logic       mem_wr;
    logic       reg_wr;
    logic       to_reg;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic alu_op_t compare_op(input logic [2:0] f3);
        alu_op_t op;
        case (f3)
            F3_BLT, F3_BGE:   op = ALU_SLT;
            F3_BLTU, F3_BGEU: op = ALU_SLTU;
            F3_BEQ, F3_BNE:   op = ALU_SUB;
            default:          op = ALU_SUB;
        endcase
        return op;
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // defaults are all zero, so a trap leaves empty control words.
    always_comb begin
        alu_op  = ALU_ADD;
        src_imm = 1'b0;
        src_pc  = 1'b0;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        reg_wr  = 1'b0;
        to_reg  = 1'b0;
        branch  = 1'b0;
        jump    = 1'b0;
        jalr    = 1'b0;
        ujtype  = 1'b0;
        excp    = 1'b0;
        case (opcode)
            OP_LUI: begin
                alu_op  = ALU_PASS_B;
                src_imm = 1'b1;
                reg_wr  = 1'b1;
                ujtype  = 1'b1;
            end
            OP_AUIPC: begin
                src_imm = 1'b1;
                src_pc  = 1'b1;
                reg_wr  = 1'b1;
                ujtype  = 1'b1;
            end
            OP_JAL: begin
                jump   = 1'b1;
                ujtype = 1'b1;
                reg_wr = 1'b1;
            end
            OP_JALR: begin
                jump    = 1'b1;
                jalr    = 1'b1;
                src_imm = 1'b1;
                reg_wr  = 1'b1;
            end
            OP_BRANCH: begin
                alu_op = compare_op(funct3);
                branch = 1'b1;
            end
            OP_LOAD: begin
                src_imm = 1'b1;
                mem_rd  = 1'b1;
                reg_wr  = 1'b1;
                to_reg  = 1'b1;
            end
            OP_STORE: begin
                src_imm = 1'b1;
                mem_wr  = 1'b1;
            end
            OP_IMM: begin
                // only the shift-right form reads funct7.
                alu_op  = arith_op(funct3, (funct3 == F3_SR) && funct7[5]);
                src_imm = 1'b1;
                reg_wr  = 1'b1;
            end
            OP_REG: begin
                alu_op = arith_op(funct3, funct7[5]);
                reg_wr = 1'b1;
            end
            OP_SYSTEM: begin
                // ecall only, other system words decode as nops.
                excp = (inst[31:7] == '0);
            end
            default: begin
                // all-zero word is a flushed if/id register.
                excp = (inst != '0);
            end
        endcase
    end

    assign ex_ctrl  = {alu_op, src_imm, src_pc, branch, jump, jalr};
    assign mem_ctrl = {mem_rd, mem_wr, (mem_rd || mem_wr) ? funct3 : 3'b000};
    assign wb_ctrl  = {reg_wr, to_reg};

endmodule

// File: branch_predictor.sv
module branch_predictor #(
    parameter rv_isa_pkg::data_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dcache_stall,
    input  logic              stall,
    input  logic              branch,
    input  logic              jump,
    input  logic              jalr,
    input  logic              excp,
    input  rv_isa_pkg::data_t pc,
    input  rv_isa_pkg::data_t imm,
    input  rv_isa_pkg::data_t rs1_data,
    input  rv_isa_pkg::data_t old_pc,
    input  rv_isa_pkg::data_t old_branch_pc,
    input  logic              old_branch,
    input  logic              old_predict,
    input  logic              old_actual,
    output rv_isa_pkg::data_t new_pc,
    output logic              redirect,
    output logic              predict_result,
    output logic              predict_fail,
    output rv_isa_pkg::data_t sepc
);
    import rv_isa_pkg::*;

    logic predict_taken;
    logic sepc_load;

    // backward taken, forward not taken.
    assign predict_taken  = branch && imm[31];
    assign predict_result = predict_taken;
    assign predict_fail   = old_branch && (old_predict != old_actual);

    always_comb begin
        redirect = 1'b1;
        if (predict_fail) begin
            new_pc = old_actual ? old_branch_pc : old_pc + 32'd4;
        end else if (excp) begin
            new_pc = TRAP_VECTOR;
        end else if (jalr) begin
            new_pc = (rs1_data + imm) & ~32'd1;
        end else if (jump || predict_taken) begin
            new_pc = pc + imm;
        end else begin
            redirect = 1'b0;
            new_pc   = pc + 32'd4;
        end
    end

    // wrong-path traps are dropped.
    assign sepc_load = excp && !stall && !dcache_stall && !predict_fail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sepc <= '0;
        end else if (sepc_load) begin
            sepc <= pc;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> !new_pc[0]);

endmodule

// File: stage_id.sv
module stage_id #(
    parameter rv_isa_pkg::data_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dcache_stall,
    input  rv_isa_pkg::data_t      pc_in,
    input  rv_isa_pkg::data_t      inst,
    input  rv_isa_pkg::reg_idx_t   id_ex_rd,
    input  logic                   id_ex_mem_read,
    input  logic                   old_branch,
    input  logic                   old_predict,
    input  logic                   branch_result,
    input  rv_isa_pkg::data_t      old_pc,
    input  rv_isa_pkg::data_t      old_branch_pc,
    input  rv_isa_pkg::reg_idx_t   mem_wb_rd,
    input  rv_isa_pkg::data_t      wb_data,
    input  logic                   reg_write,
    output id_ctrl_pkg::ex_ctrl_t  ex_ctrl,
    output id_ctrl_pkg::mem_ctrl_t mem_ctrl,
    output id_ctrl_pkg::wb_ctrl_t  wb_ctrl,
    output rv_isa_pkg::reg_idx_t   rs1_out,
    output rv_isa_pkg::reg_idx_t   rs2_out,
    output rv_isa_pkg::reg_idx_t   rd_out,
    output rv_isa_pkg::data_t      reg_data1,
    output rv_isa_pkg::data_t      reg_data2,
    output rv_isa_pkg::data_t      imm_out,
    output rv_isa_pkg::data_t      pc_out,
    output logic                   if_id_write,
    output logic                   pc_write,
    output rv_isa_pkg::data_t      new_pc,
    output logic                   redirect,
    output logic                   predict_result,
    output logic                   predict_fail,
    output rv_isa_pkg::data_t      sepc
);
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    reg_idx_t  rs1;
    reg_idx_t  rs2;
    data_t     rs1_data;
    data_t     imm;
    ex_ctrl_t  ex_raw;
    mem_ctrl_t mem_raw;
    wb_ctrl_t  wb_raw;
    logic      branch;
    logic      jump;
    logic      jalr;
    logic      ujtype;
    logic      excp;
    logic      stall;

    // u and j formats carry immediate bits in the rs1 field.
    assign rs1 = ujtype ? reg_idx_t'(0) : inst[19:15];
    assign rs2 = inst[24:20];

    assign rs1_out   = rs1;
    assign rs2_out   = rs2;
    assign rd_out    = inst[11:7];
    assign reg_data1 = rs1_data;
    assign imm_out   = imm;
    assign pc_out    = pc_in;

    // load-use bubble.
    assign ex_ctrl  = stall ? EX_NOP  : ex_raw;
    assign mem_ctrl = stall ? MEM_NOP : mem_raw;
    assign wb_ctrl  = stall ? WB_NOP  : wb_raw;

    imm_gen imm_gen_i (
        .inst (inst),
        .imm  (imm)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (mem_wb_rd),
        .wdata  (wb_data),
        .we     (reg_write),
        .rdata1 (rs1_data),
        .rdata2 (reg_data2)
    );

    hazard_unit hazard_unit_i (
        .rs1            (rs1),
        .rs2            (rs2),
        .id_ex_rd       (id_ex_rd),
        .id_ex_mem_read (id_ex_mem_read),
        .stall          (stall),
        .if_id_write    (if_id_write),
        .pc_write       (pc_write)
    );

    ctrl_decode ctrl_decode_i (
        .inst     (inst),
        .ex_ctrl  (ex_raw),
        .mem_ctrl (mem_raw),
        .wb_ctrl  (wb_raw),
        .branch   (branch),
        .jump     (jump),
        .jalr     (jalr),
        .ujtype   (ujtype),
        .excp     (excp)
    );

    branch_predictor #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) branch_predictor_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dcache_stall   (dcache_stall),
        .stall          (stall),
        .branch         (branch),
        .jump           (jump),
        .jalr           (jalr),
        .excp           (excp),
        .pc             (pc_in),
        .imm            (imm),
        .rs1_data       (rs1_data),
        .old_pc         (old_pc),
        .old_branch_pc  (old_branch_pc),
        .old_branch     (old_branch),
        .old_predict    (old_predict),
        .old_actual     (branch_result),
        .new_pc         (new_pc),
        .redirect       (redirect),
        .predict_result (predict_result),
        .predict_fail   (predict_fail),
        .sepc           (sepc)
    );

endmodule

// File: id_checker.sv
module id_checker #(
    parameter rv_isa_pkg::data_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dcache_stall,
    input  rv_isa_pkg::data_t      pc_in,
    input  rv_isa_pkg::data_t      inst,
    input  rv_isa_pkg::reg_idx_t   id_ex_rd,
    input  logic                   id_ex_mem_read,
    input  logic                   old_branch,
    input  logic                   old_predict,
    input  logic                   branch_result,
    input  rv_isa_pkg::data_t      old_pc,
    input  rv_isa_pkg::data_t      old_branch_pc,
    input  rv_isa_pkg::reg_idx_t   mem_wb_rd,
    input  rv_isa_pkg::data_t      wb_data,
    input  logic                   reg_write,
    input  id_ctrl_pkg::ex_ctrl_t  ex_ctrl,
    input  id_ctrl_pkg::mem_ctrl_t mem_ctrl,
    input  id_ctrl_pkg::wb_ctrl_t  wb_ctrl,
    input  rv_isa_pkg::reg_idx_t   rs1_out,
    input  rv_isa_pkg::reg_idx_t   rs2_out,
    input  rv_isa_pkg::reg_idx_t   rd_out,
    input  rv_isa_pkg::data_t      reg_data1,
    input  rv_isa_pkg::data_t      reg_data2,
    input  rv_isa_pkg::data_t      imm_out,
    input  rv_isa_pkg::data_t      pc_out,
    input  logic                   if_id_write,
    input  logic                   pc_write,
    input  rv_isa_pkg::data_t      new_pc,
    input  logic                   redirect,
    input  logic                   predict_result,
    input  logic                   predict_fail,
    input  rv_isa_pkg::data_t      sepc,
    output int                     errors,
    output int                     checks
);
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    data_t shadow [32];
    data_t shadow_sepc;

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(negedge rst_n) begin
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        shadow_sepc = '0;
    end

    function automatic data_t read_reg(input reg_idx_t idx);
        data_t val;
        val = shadow[idx];
        if (idx == '0) begin
            val = '0;
        end else if (reg_write && mem_wb_rd == idx) begin
            val = wb_data;
        end
        return val;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // inputs settle after the falling edge, so the rising edge sees stable outputs.
    always @(posedge clk) begin : model
        opcode_t op;
        logic [2:0] f3;
        logic alt;
        alu_op_t alu;
        logic src_imm, src_pc, br, jmp, jr, m_rd, m_wr, w_reg, w_mem, excp;
        logic uj;
        logic stall;
        logic fail;
        logic redir;
        reg_idx_t e_rs1;
        data_t e_imm;
        data_t npc;
        op = inst[6:0];
        f3 = inst[14:12];
        alu = ALU_ADD;
        {src_imm, src_pc, br, jmp, jr, m_rd, m_wr, w_reg, w_mem, excp} = '0;
        e_imm = '0;
        case (op)
            OP_LUI, OP_AUIPC: begin
                e_imm = {inst[31:12], 12'h000};
                alu = (op == OP_LUI) ? ALU_PASS_B : ALU_ADD;
                src_imm = 1'b1;
                src_pc = (op == OP_AUIPC);
                w_reg = 1'b1;
            end
            OP_JAL: begin
                e_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                jmp = 1'b1;
                w_reg = 1'b1;
            end
            OP_JALR, OP_LOAD, OP_IMM: begin
                e_imm = {{20{inst[31]}}, inst[31:20]};
                src_imm = 1'b1;
                w_reg = 1'b1;
                jmp = (op == OP_JALR);
                jr = (op == OP_JALR);
                m_rd = (op == OP_LOAD);
                w_mem = (op == OP_LOAD);
            end
            OP_STORE: begin
                e_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                src_imm = 1'b1;
                m_wr = 1'b1;
            end
            OP_BRANCH: begin
                e_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                br = 1'b1;
                alu = (f3[2:1] == 2'b10) ? ALU_SLT : (f3[2:1] == 2'b11) ? ALU_SLTU : ALU_SUB;
            end
            OP_REG: w_reg = 1'b1;
            OP_SYSTEM: excp = (inst[31:7] == '0);
            default: excp = (inst != '0);
        endcase
        if (op == OP_IMM || op == OP_REG) begin
            alt = inst[30] && (op == OP_REG || f3 == 3'b101);
            case (f3)
                3'b000: alu = alt ? ALU_SUB : ALU_ADD;
                3'b001: alu = ALU_SLL;
                3'b010: alu = ALU_SLT;
                3'b011: alu = ALU_SLTU;
                3'b100: alu = ALU_XOR;
                3'b101: alu = alt ? ALU_SRA : ALU_SRL;
                3'b110: alu = ALU_OR;
                default: alu = ALU_AND;
            endcase
        end
        uj = (op == OP_LUI) || (op == OP_AUIPC) || (op == OP_JAL);
        e_rs1 = uj ? reg_idx_t'(0) : inst[19:15];
        stall = id_ex_mem_read && id_ex_rd != '0 && (id_ex_rd == e_rs1 || id_ex_rd == inst[24:20]);
        fail = old_branch && (old_predict != branch_result);
        redir = 1'b1;
        if (fail) begin
            npc = branch_result ? old_branch_pc : old_pc + 32'd4;
        end else if (excp) begin
            npc = TRAP_VECTOR;
        end else if (jr) begin
            npc = (read_reg(e_rs1) + e_imm) & ~32'd1;
        end else if (jmp || (br && e_imm[31])) begin
            npc = pc_in + e_imm;
        end else begin
            redir = 1'b0;
            npc = pc_in + 32'd4;
        end
        check_val("ex_ctrl", ex_ctrl, stall ? 9'd0 : {alu, src_imm, src_pc, br, jmp, jr});
        check_val("mem_ctrl", mem_ctrl, stall ? 5'd0 : {m_rd, m_wr, (m_rd || m_wr) ? f3 : 3'b0});
        check_val("wb_ctrl", wb_ctrl, stall ? 2'd0 : {w_reg, w_mem});
        check_val("rs1_out", rs1_out, e_rs1);
        check_val("rs2_out", rs2_out, inst[24:20]);
        check_val("rd_out", rd_out, inst[11:7]);
        check_val("reg_data1", reg_data1, read_reg(e_rs1));
        check_val("reg_data2", reg_data2, read_reg(inst[24:20]));
        check_val("imm_out", imm_out, e_imm);
        check_val("pc_out", pc_out, pc_in);
        check_val("if_id_write", if_id_write, !stall);
        check_val("pc_write", pc_write, !stall);
        check_val("new_pc", new_pc, npc);
        check_val("redirect", redirect, redir);
        check_val("predict_result", predict_result, br && e_imm[31]);
        check_val("predict_fail", predict_fail, fail);
        check_val("sepc", sepc, shadow_sepc);
        if (rst_n) begin
            if (reg_write && mem_wb_rd != '0) begin
                shadow[mem_wb_rd] = wb_data;
            end
            if (excp && !stall && !dcache_stall && !fail) begin
                shadow_sepc = pc_in;
            end
        end
    end

endmodule

// File: tb_stage_id.sv
module tb_stage_id;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    localparam data_t TRAP_VECTOR = 32'h0000_0100;
    localparam int RST_CYCLES = 5;
    localparam int N_RESET = 4;
    localparam int N_RF = 200;
    localparam int N_DEC = 300;
    localparam int N_HAZ = 200;
    localparam int N_RED = 200;
    localparam int N_EXC = 200;
    localparam int MARGIN = 50;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + N_RESET + N_RF + N_DEC + N_HAZ + N_RED
        + N_EXC + MARGIN;

    logic clk;
    logic rst_n;
    logic dcache_stall;
    data_t pc_in;
    data_t inst;
    reg_idx_t id_ex_rd;
    logic id_ex_mem_read;
    logic old_branch;
    logic old_predict;
    logic branch_result;
    data_t old_pc;
    data_t old_branch_pc;
    reg_idx_t mem_wb_rd;
    data_t wb_data;
    logic reg_write;
    ex_ctrl_t ex_ctrl;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t wb_ctrl;
    reg_idx_t rs1_out;
    reg_idx_t rs2_out;
    reg_idx_t rd_out;
    data_t reg_data1;
    data_t reg_data2;
    data_t imm_out;
    data_t pc_out;
    logic if_id_write;
    logic pc_write;
    data_t new_pc;
    logic redirect;
    logic predict_result;
    logic predict_fail;
    data_t sepc;

    int errors;
    int checks;
    int last_errors;
    data_t seed;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    stage_id #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) stage_id_i (
        .clk (clk), .rst_n (rst_n), .dcache_stall (dcache_stall),
        .pc_in (pc_in), .inst (inst), .id_ex_rd (id_ex_rd),
        .id_ex_mem_read (id_ex_mem_read), .old_branch (old_branch),
        .old_predict (old_predict), .branch_result (branch_result),
        .old_pc (old_pc), .old_branch_pc (old_branch_pc), .mem_wb_rd (mem_wb_rd),
        .wb_data (wb_data), .reg_write (reg_write), .ex_ctrl (ex_ctrl),
        .mem_ctrl (mem_ctrl), .wb_ctrl (wb_ctrl), .rs1_out (rs1_out),
        .rs2_out (rs2_out), .rd_out (rd_out), .reg_data1 (reg_data1),
        .reg_data2 (reg_data2), .imm_out (imm_out), .pc_out (pc_out),
        .if_id_write (if_id_write), .pc_write (pc_write), .new_pc (new_pc),
        .redirect (redirect), .predict_result (predict_result),
        .predict_fail (predict_fail), .sepc (sepc)
    );

    id_checker #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) id_checker_i (
        .clk (clk), .rst_n (rst_n), .dcache_stall (dcache_stall),
        .pc_in (pc_in), .inst (inst), .id_ex_rd (id_ex_rd),
        .id_ex_mem_read (id_ex_mem_read), .old_branch (old_branch),
        .old_predict (old_predict), .branch_result (branch_result),
        .old_pc (old_pc), .old_branch_pc (old_branch_pc), .mem_wb_rd (mem_wb_rd),
        .wb_data (wb_data), .reg_write (reg_write), .ex_ctrl (ex_ctrl),
        .mem_ctrl (mem_ctrl), .wb_ctrl (wb_ctrl), .rs1_out (rs1_out),
        .rs2_out (rs2_out), .rd_out (rd_out), .reg_data1 (reg_data1),
        .reg_data2 (reg_data2), .imm_out (imm_out), .pc_out (pc_out),
        .if_id_write (if_id_write), .pc_write (pc_write), .new_pc (new_pc),
        .redirect (redirect), .predict_result (predict_result),
        .predict_fail (predict_fail), .sepc (sepc),
        .errors (errors), .checks (checks)
    );

    // xorshift32.
    function automatic data_t next_rand();
        data_t x;
        x = seed;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        seed = x;
        return x;
    endfunction

    // kinds 0..9 follow the opcode list, 10 is ecall, 11 an illegal opcode.
    function automatic data_t make_inst(input int kind);
        data_t r;
        opcode_t op;
        data_t word;
        r = next_rand();
        case (kind)
            0: op = OP_LUI;
            1: op = OP_AUIPC;
            2: op = OP_JAL;
            3: op = OP_JALR;
            4: op = OP_BRANCH;
            5: op = OP_LOAD;
            6: op = OP_STORE;
            7: op = OP_IMM;
            8: op = OP_REG;
            9, 10: op = OP_SYSTEM;
            default: begin
                case (r[1:0])
                    2'd0: op = 7'b0001111;
                    2'd1: op = 7'b1111111;
                    2'd2: op = 7'b0101111;
                    default: op = 7'b1011011;
                endcase
            end
        endcase
        word = {r[31:7], op};
        if (kind == 10) begin
            word = {25'b0, OP_SYSTEM};
        end
        return word;
    endfunction

    task automatic set_idle();
        dcache_stall = 1'b0;
        pc_in = '0;
        inst = '0;
        id_ex_rd = '0;
        id_ex_mem_read = 1'b0;
        old_branch = 1'b0;
        old_predict = 1'b0;
        branch_result = 1'b0;
        old_pc = '0;
        old_branch_pc = '0;
        mem_wb_rd = '0;
        wb_data = '0;
        reg_write = 1'b0;
    endtask

    // pc values stay word aligned.
    task automatic randomize_side();
        data_t r;
        r = next_rand();
        dcache_stall = (r[2:0] == 3'd0);
        id_ex_rd = r[7:3];
        id_ex_mem_read = (r[9:8] == 2'd0);
        old_branch = (r[11:10] == 2'd0);
        old_predict = r[12];
        branch_result = r[13];
        mem_wb_rd = r[18:14];
        reg_write = r[19];
        pc_in = {next_rand() >> 2, 2'b00};
        old_pc = {next_rand() >> 2, 2'b00};
        old_branch_pc = {next_rand() >> 2, 2'b00};
        wb_data = next_rand();
    endtask

    task automatic apply_stimulus(input int id, input int i, input int n);
        data_t r;
        randomize_side();
        r = next_rand();
        case (id)
            1: set_idle();
            2: begin
                inst = make_inst(r[0] ? 8 : 7);
                reg_write = (i < n / 2) || r[1];
                id_ex_mem_read = 1'b0;
                old_branch = 1'b0;
                // same-cycle bypass.
                if (r[2]) begin
                    mem_wb_rd = inst[19:15];
                end
            end
            3: begin
                inst = make_inst(int'(r % 10));
                id_ex_mem_read = 1'b0;
                old_branch = 1'b0;
            end
            4: begin
                inst = make_inst(int'(r % 10));
                id_ex_mem_read = r[4];
                old_branch = 1'b0;
                case (r[6:5])
                    2'd0: id_ex_rd = inst[19:15];
                    2'd1: id_ex_rd = inst[24:20];
                    2'd2: id_ex_rd = '0;
                    default: id_ex_rd = r[11:7];
                endcase
            end
            5: begin
                inst = make_inst(2 + int'(r % 3));
                old_branch = (r[5:4] == 2'd0);
            end
            default: begin
                case (r % 3)
                    0: inst = make_inst(10);
                    1: inst = make_inst(11);
                    default: inst = make_inst(int'(next_rand() % 10));
                endcase
                id_ex_mem_read = r[4];
                dcache_stall = (r[6:5] == 2'd0);
                if (r[7]) begin
                    id_ex_rd = inst[24:20];
                end
            end
        endcase
    endtask

    task automatic run_test(input int id, input string name, input int n);
        for (int i = 0; i < n; i++) begin
            apply_stimulus(id, i, n);
            @(negedge clk);
        end
        $display("test %0d %s %0d cycles, %0d errors, %s", id, name, n,
            errors - last_errors, (errors == last_errors) ? "ok" : "bad");
        last_errors = errors;
    endtask

    initial begin
        seed = 32'h0a0845e3;
        last_errors = 0;
        set_idle();
        rst_n = 1'b1;
        #1;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_test(1, "reset", N_RESET);
        run_test(2, "reg_file", N_RF);
        run_test(3, "decode", N_DEC);
        run_test(4, "hazard", N_HAZ);
        run_test(5, "redirect", N_RED);
        run_test(6, "exception", N_EXC);
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog expired after %0d cycles, tests did not complete",
            WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: filelist.f
rv_isa_pkg.sv
id_ctrl_pkg.sv
imm_gen.sv
reg_file.sv
hazard_unit.sv
ctrl_decode.sv
branch_predictor.sv
stage_id.sv
id_checker.sv
tb_stage_id.sv

// File: Bender.yml
package:
  name: stage_id

sources:
  - rv_isa_pkg.sv
  - id_ctrl_pkg.sv
  - imm_gen.sv
  - reg_file.sv
  - hazard_unit.sv
  - ctrl_decode.sv
  - branch_predictor.sv
  - stage_id.sv
  - target: test
    files:
      - id_checker.sv
      - tb_stage_id.sv
